// ==== flist.f ====
+incdir+src
src/lsu_pkg.sv
src/lsu_dispatch.sv
src/lsu_unit.sv
src/lsu_axi_arbiter.sv
src/lsu_top.sv
testbench/axi_mem_model.sv
testbench/lsu_tb.sv

// ==== src/lsu_axi_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lsu_config.svh"

module lsu_axi_arbiter (
  input  logic                                   clock,
  input  logic                                   reset,

  input  logic [`LSU_UNITS-1:0]                  ar_valid,
  input  lsu_pkg::lsu_ar_t [`LSU_UNITS-1:0]      ar,
  output logic [`LSU_UNITS-1:0]                  ar_ready,
  input  logic [`LSU_UNITS-1:0]                  aw_valid,
  input  lsu_pkg::lsu_aw_t [`LSU_UNITS-1:0]      aw,
  output logic [`LSU_UNITS-1:0]                  aw_ready,
  output logic [`LSU_UNITS-1:0]                  r_valid,
  output lsu_pkg::lsu_r_t [`LSU_UNITS-1:0]       r,
  output logic [`LSU_UNITS-1:0]                  b_valid,
  output lsu_pkg::lsu_b_t [`LSU_UNITS-1:0]       b,

  output logic                                   axi_arvalid,
  output lsu_pkg::lsu_ar_t                       axi_ar,
  input  logic                                   axi_arready,
  input  logic                                   axi_rvalid,
  input  lsu_pkg::lsu_r_t                        axi_r,
  output logic                                   axi_rready,
  output logic                                   axi_awvalid,
  output logic                                   axi_wvalid,
  output lsu_pkg::lsu_aw_t                       axi_aw,
  input  logic                                   axi_awready,
  input  logic                                   axi_wready,
  input  logic                                   axi_bvalid,
  input  lsu_pkg::lsu_b_t                        axi_b,
  output logic                                   axi_bready
);

  import lsu_pkg::*;

  logic    rd_busy_q;
  lsu_id_t rd_grant_q;
  lsu_id_t rd_ptr_q; // Unit checked first on the next read grant
  lsu_ar_t axi_ar_q;

  logic    wr_busy_q;
  lsu_id_t wr_grant_q;
  lsu_id_t wr_ptr_q;
  lsu_aw_t axi_aw_q;
  logic    aw_done_q;
  logic    w_done_q;
  logic    wr_complete; // Both AW and W accepted by this cycle

  // First requesting unit at or after ptr, wrapping around
  function automatic lsu_id_t rr_pick(input logic [`LSU_UNITS-1:0] valid, input lsu_id_t ptr);
    lsu_id_t pick;
    logic found;
    pick = ptr;
    found = 1'b0;
    for (int k = 0; k < `LSU_UNITS; k++) begin
      if (!found && valid[(int'(ptr) + k) % `LSU_UNITS]) begin
        pick = lsu_id_t'((int'(ptr) + k) % `LSU_UNITS);
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read address channel

  assign axi_arvalid = rd_busy_q;
  assign axi_ar = axi_ar_q;

  always_comb begin
    ar_ready = '0;
    ar_ready[rd_grant_q] = rd_busy_q && axi_arready;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_busy_q <= 1'b0;
      rd_grant_q <= '0;
      rd_ptr_q <= '0;
    end else if (rd_busy_q) begin
      if (axi_arready) begin
        rd_busy_q <= 1'b0;
        rd_ptr_q <= lsu_id_t'((int'(rd_grant_q) + 1) % `LSU_UNITS);
      end
    end else if (|ar_valid) begin
      rd_busy_q <= 1'b1;
      rd_grant_q <= rr_pick(ar_valid, rd_ptr_q);
    end
  end

  always_ff @(posedge clock) begin
    if (!rd_busy_q && |ar_valid) begin
      axi_ar_q <= ar[rr_pick(ar_valid, rd_ptr_q)];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write address and data channels

  assign axi_awvalid = wr_busy_q && !aw_done_q;
  assign axi_wvalid = wr_busy_q && !w_done_q;
  assign axi_aw = axi_aw_q;
  assign wr_complete = wr_busy_q && (aw_done_q || axi_awready) && (w_done_q || axi_wready);

  always_comb begin
    aw_ready = '0;
    aw_ready[wr_grant_q] = wr_complete;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_busy_q <= 1'b0;
      wr_grant_q <= '0;
      wr_ptr_q <= '0;
      aw_done_q <= 1'b0;
      w_done_q <= 1'b0;
    end else if (wr_busy_q) begin
      if (wr_complete) begin
        wr_busy_q <= 1'b0;
        aw_done_q <= 1'b0;
        w_done_q <= 1'b0;
        wr_ptr_q <= lsu_id_t'((int'(wr_grant_q) + 1) % `LSU_UNITS);
      end else begin
        aw_done_q <= aw_done_q || axi_awready;
        w_done_q <= w_done_q || axi_wready;
      end
    end else if (|aw_valid) begin
      wr_busy_q <= 1'b1;
      wr_grant_q <= rr_pick(aw_valid, wr_ptr_q);
    end
  end

  always_ff @(posedge clock) begin
    if (!wr_busy_q && |aw_valid) begin
      axi_aw_q <= aw[rr_pick(aw_valid, wr_ptr_q)];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Responses, routed by ID

  assign axi_rready = 1'b1; // The owner of every ID is waiting
  assign axi_bready = 1'b1;

  always_comb begin
    for (int i = 0; i < `LSU_UNITS; i++) begin
      r_valid[i] = axi_rvalid && (axi_r.id == lsu_id_t'(i));
      b_valid[i] = axi_bvalid && (axi_b.id == lsu_id_t'(i));
      r[i] = axi_r;
      b[i] = axi_b;
    end
  end

endmodule

`default_nettype wire

// ==== src/lsu_config.svh ====
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store block sizing

`define LSU_UNITS 4 // Accesses in flight at once
`define LSU_TAG_WIDTH 4 // Tag returned with each result

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory map

// Upper address bits of the 4 KiB page that answers SLVERR
`define LSU_ERR_BASE 20'h1_0000

`endif

// ==== src/lsu_dispatch.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lsu_config.svh"

module lsu_dispatch (
  input  logic                      clock,
  input  logic                      reset,

  input  logic                      req_valid,
  input  lsu_pkg::lsu_req_t         req,
  output logic                      full,

  input  logic [`LSU_UNITS-1:0]     busy,
  output logic [`LSU_UNITS-1:0]     start,
  output lsu_pkg::lsu_req_t         unit_req
);

  logic [`LSU_UNITS-1:0] started_q; // Units started in the previous cycle
  logic [`LSU_UNITS-1:0] taken;
  logic [`LSU_UNITS-1:0] first_idle; // One-hot, lowest idle unit
  logic                  any_idle;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Idle tracking

  assign taken = busy | started_q; // Busy flag lags start by a cycle
  assign any_idle = ~&taken;
  assign full = ~any_idle;

  always_comb begin
    logic found;
    found = 1'b0;
    first_idle = '0;
    for (int i = 0; i < `LSU_UNITS; i++) begin
      if (!found && !taken[i]) begin
        first_idle[i] = 1'b1;
        found = 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Steering

  // A request arriving while full is dropped here
  always_comb begin
    start = '0;
    if (req_valid && any_idle) begin
      start = first_idle;
    end
  end

  assign unit_req = req; // Every unit sees the payload, only one is started

  always_ff @(posedge clock) begin
    if (reset) begin
      started_q <= '0;
    end else begin
      started_q <= start;
    end
  end

endmodule

`default_nettype wire

// ==== src/lsu_pkg.sv ====
`default_nettype none

`include "lsu_config.svh"

package lsu_pkg;

  typedef logic [31:0] lsu_addr_t;
  typedef logic [31:0] lsu_data_t;
  typedef logic [3:0] lsu_strb_t;
  typedef logic [`LSU_TAG_WIDTH-1:0] lsu_tag_t;
  typedef logic [1:0] lsu_id_t; // Unit index, doubles as AXI ID
  typedef logic [1:0] lsu_resp_t;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } lsu_size_e; // Same codes as AXI AxSIZE

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ_ADDR,
    ST_READ_DATA,
    ST_WRITE,
    ST_WRITE_RESP
  } lsu_state_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Requester side

  typedef struct packed {
    logic write;
    lsu_size_e size;
    logic sext;
    lsu_addr_t addr;
    lsu_data_t wsrc; // Store source, unshifted
    lsu_tag_t tag;
  } lsu_req_t;

  typedef struct packed {
    lsu_tag_t tag;
    logic write;
    logic error;
    lsu_data_t rdata; // Aligned and extended load data
  } lsu_result_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // AXI4-Lite channel payloads

  typedef struct packed {
    lsu_id_t id;
    lsu_addr_t addr;
    lsu_size_e size;
  } lsu_ar_t;

  typedef struct packed {
    lsu_id_t id;
    lsu_addr_t addr;
    lsu_size_e size;
    lsu_data_t wdata;
    lsu_strb_t wstrb;
  } lsu_aw_t;

  typedef struct packed {
    lsu_id_t id;
    lsu_data_t rdata;
    lsu_resp_t resp;
  } lsu_r_t;

  typedef struct packed {
    lsu_id_t id;
    lsu_resp_t resp;
  } lsu_b_t;

endpackage

`default_nettype wire

// ==== src/lsu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lsu_config.svh"

module lsu_top (
  input  logic                                      clock,
  input  logic                                      reset,

  input  logic                                      req_valid,
  input  lsu_pkg::lsu_req_t                         req,
  output logic                                      full,
  output logic [`LSU_UNITS-1:0]                     result_valid,
  output lsu_pkg::lsu_result_t [`LSU_UNITS-1:0]     result,

  output logic                                      axi_arvalid,
  output lsu_pkg::lsu_ar_t                          axi_ar,
  input  logic                                      axi_arready,
  input  logic                                      axi_rvalid,
  input  lsu_pkg::lsu_r_t                           axi_r,
  output logic                                      axi_rready,
  output logic                                      axi_awvalid,
  output logic                                      axi_wvalid,
  output lsu_pkg::lsu_aw_t                          axi_aw,
  input  logic                                      axi_awready,
  input  logic                                      axi_wready,
  input  logic                                      axi_bvalid,
  input  lsu_pkg::lsu_b_t                           axi_b,
  output logic                                      axi_bready
);

  import lsu_pkg::*;

  logic [`LSU_UNITS-1:0]   busy;
  logic [`LSU_UNITS-1:0]   start;
  lsu_req_t                unit_req;

  logic [`LSU_UNITS-1:0]   ar_valid;
  lsu_ar_t [`LSU_UNITS-1:0] ar;
  logic [`LSU_UNITS-1:0]   ar_ready;
  logic [`LSU_UNITS-1:0]   aw_valid;
  lsu_aw_t [`LSU_UNITS-1:0] aw;
  logic [`LSU_UNITS-1:0]   aw_ready;
  logic [`LSU_UNITS-1:0]   r_valid;
  lsu_r_t [`LSU_UNITS-1:0] r;
  logic [`LSU_UNITS-1:0]   b_valid;
  lsu_b_t [`LSU_UNITS-1:0] b;

  lsu_dispatch dispatch0 (
    .clock(clock),
    .reset(reset),
    .req_valid(req_valid),
    .req(req),
    .full(full),
    .busy(busy),
    .start(start),
    .unit_req(unit_req)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Load/store units, one AXI ID each

  for (genvar i = 0; i < `LSU_UNITS; i++) begin : g_unit
    lsu_unit unit0 (
      .clock(clock),
      .reset(reset),
      .start(start[i]),
      .req(unit_req),
      .unit_id(lsu_id_t'(i)),
      .busy(busy[i]),
      .ar_valid(ar_valid[i]),
      .ar(ar[i]),
      .ar_ready(ar_ready[i]),
      .aw_valid(aw_valid[i]),
      .aw(aw[i]),
      .aw_ready(aw_ready[i]),
      .r_valid(r_valid[i]),
      .r(r[i]),
      .b_valid(b_valid[i]),
      .b(b[i]),
      .result_valid(result_valid[i]),
      .result(result[i])
    );
  end

  lsu_axi_arbiter arbiter0 (
    .clock(clock),
    .reset(reset),
    .ar_valid(ar_valid),
    .ar(ar),
    .ar_ready(ar_ready),
    .aw_valid(aw_valid),
    .aw(aw),
    .aw_ready(aw_ready),
    .r_valid(r_valid),
    .r(r),
    .b_valid(b_valid),
    .b(b),
    .axi_arvalid(axi_arvalid),
    .axi_ar(axi_ar),
    .axi_arready(axi_arready),
    .axi_rvalid(axi_rvalid),
    .axi_r(axi_r),
    .axi_rready(axi_rready),
    .axi_awvalid(axi_awvalid),
    .axi_wvalid(axi_wvalid),
    .axi_aw(axi_aw),
    .axi_awready(axi_awready),
    .axi_wready(axi_wready),
    .axi_bvalid(axi_bvalid),
    .axi_b(axi_b),
    .axi_bready(axi_bready)
  );

endmodule

`default_nettype wire

// ==== src/lsu_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_unit (
  input  logic                  clock,
  input  logic                  reset,

  input  logic                  start,
  input  lsu_pkg::lsu_req_t     req,
  input  lsu_pkg::lsu_id_t      unit_id,
  output logic                  busy,

  output logic                  ar_valid,
  output lsu_pkg::lsu_ar_t      ar,
  input  logic                  ar_ready,

  output logic                  aw_valid,
  output lsu_pkg::lsu_aw_t      aw,
  input  logic                  aw_ready,

  input  logic                  r_valid,
  input  lsu_pkg::lsu_r_t       r,

  input  logic                  b_valid,
  input  lsu_pkg::lsu_b_t       b,

  output logic                  result_valid,
  output lsu_pkg::lsu_result_t  result
);

  import lsu_pkg::*;

  lsu_state_e  state;
  lsu_req_t    req_q;
  logic [4:0]  lane_shift; // Bit offset of the addressed byte lane
  logic        sub_word;
  lsu_strb_t   size_mask;
  lsu_data_t   store_data;
  lsu_data_t   load_aligned;
  lsu_data_t   load_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Byte lanes

  assign lane_shift = {req_q.addr[1:0], 3'b000};
  assign sub_word = (req_q.size != SIZE_WORD);

  always_comb begin
    case (req_q.size)
      SIZE_BYTE: size_mask = 4'b0001;
      SIZE_HALF: size_mask = 4'b0011;
      default:   size_mask = 4'b1111;
    endcase
  end

  assign store_data = sub_word ? (req_q.wsrc << lane_shift) : req_q.wsrc;
  assign load_aligned = sub_word ? (r.rdata >> lane_shift) : r.rdata;

  always_comb begin
    case (req_q.size)
      SIZE_BYTE: begin
        if (req_q.sext) begin
          load_data = {{24{load_aligned[7]}}, load_aligned[7:0]};
        end else begin
          load_data = {24'b0, load_aligned[7:0]};
        end
      end
      SIZE_HALF: begin
        if (req_q.sext) begin
          load_data = {{16{load_aligned[15]}}, load_aligned[15:0]};
        end else begin
          load_data = {16'b0, load_aligned[15:0]};
        end
      end
      default: load_data = load_aligned;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus requests

  assign busy = (state != ST_IDLE);
  assign ar_valid = (state == ST_READ_ADDR);
  assign aw_valid = (state == ST_WRITE); // Address and data go out together

  assign ar.id = unit_id;
  assign ar.addr = req_q.addr;
  assign ar.size = req_q.size;

  assign aw.id = unit_id;
  assign aw.addr = req_q.addr;
  assign aw.size = req_q.size;
  assign aw.wdata = store_data;
  assign aw.wstrb = lsu_strb_t'(size_mask << req_q.addr[1:0]);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Access sequencing

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_IDLE;
      result_valid <= 1'b0;
    end else begin
      result_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= req.write ? ST_WRITE : ST_READ_ADDR;
          end
        end
        ST_READ_ADDR: begin
          if (ar_ready) begin
            state <= ST_READ_DATA;
          end
        end
        ST_READ_DATA: begin
          if (r_valid) begin
            state <= ST_IDLE;
            result_valid <= 1'b1;
          end
        end
        ST_WRITE: begin
          if (aw_ready) begin
            state <= ST_WRITE_RESP;
          end
        end
        ST_WRITE_RESP: begin
          if (b_valid) begin
            state <= ST_IDLE;
            result_valid <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == ST_IDLE && start) begin
      req_q <= req;
    end
    if (state == ST_READ_DATA && r_valid) begin
      result.tag <= req_q.tag;
      result.write <= 1'b0;
      result.error <= (r.resp != 2'b00);
      result.rdata <= load_data;
    end
    if (state == ST_WRITE_RESP && b_valid) begin
      result.tag <= req_q.tag;
      result.write <= 1'b1;
      result.error <= (b.resp != 2'b00);
      result.rdata <= '0; // Stores return no data
    end
  end

endmodule

`default_nettype wire

// ==== testbench/axi_mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lsu_config.svh"

module axi_mem_model #(
  parameter int SEED = 32'h216c_5548
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              stall, // Holds off every new handshake

  input  logic              axi_arvalid,
  input  lsu_pkg::lsu_ar_t  axi_ar,
  output logic              axi_arready,
  output logic              axi_rvalid,
  output lsu_pkg::lsu_r_t   axi_r,
  input  logic              axi_rready,
  input  logic              axi_awvalid,
  input  logic              axi_wvalid,
  input  lsu_pkg::lsu_aw_t  axi_aw,
  output logic              axi_awready,
  output logic              axi_wready,
  output logic              axi_bvalid,
  output lsu_pkg::lsu_b_t   axi_b,
  input  logic              axi_bready
);

  import lsu_pkg::*;

  logic [31:0] mem [0:1023]; // Every 4 KiB page aliases onto this array
  integer      seed;
  logic        rd_pend;
  lsu_ar_t     ar_q;
  int          rd_wait;
  logic        wr_pend;
  lsu_id_t     wr_id;
  logic        wr_err;
  int          wr_wait;

  function automatic logic in_err_page(input lsu_addr_t addr);
    return addr[31:12] == `LSU_ERR_BASE;
  endfunction

  initial begin
    seed = SEED;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 32'h9e37_79b9 * (i + 1);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read side, one access at a time

  always @(posedge clock) begin
    if (reset) begin
      axi_arready <= 1'b0;
      axi_rvalid <= 1'b0;
      axi_r <= '0;
      rd_pend <= 1'b0;
      rd_wait <= 0;
    end else begin
      axi_arready <= 1'b0;
      if (axi_rvalid && axi_rready) begin
        axi_rvalid <= 1'b0;
      end
      if (axi_arvalid && axi_arready) begin
        rd_pend <= 1'b1;
        ar_q <= axi_ar;
        rd_wait <= $random(seed) & 3;
      end else if (rd_pend) begin
        if (rd_wait != 0) begin
          rd_wait <= rd_wait - 1;
        end else if (!axi_rvalid && !stall) begin
          axi_rvalid <= 1'b1;
          axi_r.id <= ar_q.id;
          axi_r.rdata <= mem[ar_q.addr[11:2]];
          axi_r.resp <= in_err_page(ar_q.addr) ? 2'b10 : 2'b00; // SLVERR
          rd_pend <= 1'b0;
        end
      end else if (axi_arvalid && !axi_rvalid && !stall && ($random(seed) & 1)) begin
        axi_arready <= 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write side, AW and W accepted together

  always @(posedge clock) begin
    if (reset) begin
      axi_awready <= 1'b0;
      axi_wready <= 1'b0;
      axi_bvalid <= 1'b0;
      axi_b <= '0;
      wr_pend <= 1'b0;
      wr_wait <= 0;
    end else begin
      axi_awready <= 1'b0;
      axi_wready <= 1'b0;
      if (axi_bvalid && axi_bready) begin
        axi_bvalid <= 1'b0;
      end
      if (axi_awvalid && axi_awready) begin
        wr_pend <= 1'b1;
        wr_id <= axi_aw.id;
        wr_err <= in_err_page(axi_aw.addr);
        wr_wait <= $random(seed) & 3;
        if (!in_err_page(axi_aw.addr)) begin
          for (int j = 0; j < 4; j++) begin
            if (axi_aw.wstrb[j]) begin
              mem[axi_aw.addr[11:2]][8*j +: 8] <= axi_aw.wdata[8*j +: 8];
            end
          end
        end
      end else if (wr_pend) begin
        if (wr_wait != 0) begin
          wr_wait <= wr_wait - 1;
        end else if (!axi_bvalid && !stall) begin
          axi_bvalid <= 1'b1;
          axi_b.id <= wr_id;
          axi_b.resp <= wr_err ? 2'b10 : 2'b00;
          wr_pend <= 1'b0;
        end
      end else if (axi_awvalid && axi_wvalid && !axi_bvalid && !stall && ($random(seed) & 1)) begin
        axi_awready <= 1'b1;
        axi_wready <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/lsu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lsu_config.svh"

module lsu_tb;

  import lsu_pkg::*;

  localparam int TIMEOUT = 2000; // Cycles allowed for any single wait
  localparam int TAGS = 1 << `LSU_TAG_WIDTH;

  logic clock = 1'b0;
  logic reset;
  logic req_valid;
  lsu_req_t req;
  logic full;
  logic stall;
  logic [`LSU_UNITS-1:0] result_valid;
  lsu_result_t [`LSU_UNITS-1:0] result;

  logic axi_arvalid;
  lsu_ar_t axi_ar;
  logic axi_arready;
  logic axi_rvalid;
  lsu_r_t axi_r;
  logic axi_rready;
  logic axi_awvalid;
  logic axi_wvalid;
  lsu_aw_t axi_aw;
  logic axi_awready;
  logic axi_wready;
  logic axi_bvalid;
  lsu_b_t axi_b;
  logic axi_bready;

  integer seed;
  logic [7:0] shadow [0:4095]; // Byte image of the aliased low page
  logic exp_pending [0:TAGS-1];
  logic exp_write [0:TAGS-1];
  logic exp_error [0:TAGS-1];
  logic exp_check [0:TAGS-1];
  lsu_data_t exp_data [0:TAGS-1];
  lsu_req_t sent_req [0:TAGS-1];
  int in_flight; // Requests the dispatcher counts as taken
  logic after_reset;
  logic saw_full;
  lsu_req_t cur_store;
  lsu_tag_t next_tag;

  lsu_top dut0 (.*);

  axi_mem_model #(.SEED(32'h216c_5548)) mem0 (.*);

  always #50 clock = ~clock;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Failure reporting

  task automatic stop_run();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    stop_run();
  endtask

  task automatic fail_text(input string what);
    $display("At %0t: %s", $time, what);
    stop_run();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Expected values

  function automatic int access_bytes(input lsu_size_e size);
    return (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
  endfunction

  // Lanes from the addressed byte up to the end of the access
  function automatic lsu_strb_t lane_mask(input lsu_req_t r);
    lsu_strb_t m;
    int first;
    first = r.addr[1:0];
    m = '0;
    for (int j = first; j < first + access_bytes(r.size) && j < 4; j++) begin
      m[j] = 1'b1;
    end
    return m;
  endfunction

  // Source byte k lands on lane k plus the byte offset
  function automatic lsu_data_t lane_data(input lsu_req_t r);
    lsu_data_t d;
    int first;
    first = r.addr[1:0];
    d = '0;
    for (int j = first; j < 4; j++) begin
      d[8*j +: 8] = r.wsrc[8*(j-first) +: 8];
    end
    return d;
  endfunction

  function automatic lsu_data_t shadow_load(input lsu_req_t r);
    lsu_data_t raw;
    int n;
    raw = '0;
    n = access_bytes(r.size);
    for (int k = 0; k < n; k++) begin
      raw[8*k +: 8] = shadow[r.addr[11:0] + k];
    end
    if (r.sext && n == 1 && raw[7]) begin
      raw[31:8] = '1;
    end
    if (r.sext && n == 2 && raw[15]) begin
      raw[31:16] = '1;
    end
    return raw;
  endfunction

  task automatic shadow_store(input lsu_req_t r);
    lsu_strb_t m;
    lsu_data_t d;
    m = lane_mask(r);
    d = lane_data(r);
    for (int j = 0; j < 4; j++) begin
      if (m[j]) begin
        shadow[{r.addr[11:2], 2'b00} + j] = d[8*j +: 8];
      end
    end
  endtask

  // A read on the bus has to belong to some load still waiting for its result
  function automatic logic ar_matches_load(input lsu_ar_t a);
    logic hit;
    hit = 1'b0;
    for (int t = 0; t < TAGS; t++) begin
      if (exp_pending[t] && !sent_req[t].write && sent_req[t].addr == a.addr
          && sent_req[t].size == a.size) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic check_result(input lsu_result_t res);
    assert (exp_pending[res.tag]) else fail_text("result arrived for a tag with nothing pending");
    assert (res.write == exp_write[res.tag])
      else fail_value("result.write", res.write, exp_write[res.tag]);
    assert (res.error == exp_error[res.tag])
      else fail_value("result.error", res.error, exp_error[res.tag]);
    if (exp_check[res.tag] && !exp_write[res.tag]) begin
      assert (res.rdata == exp_data[res.tag])
        else fail_value("result.rdata", res.rdata, exp_data[res.tag]);
    end
    exp_pending[res.tag] = 1'b0;
    in_flight--;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Monitor, sampled on the falling edge

  always @(negedge clock) begin
    if (reset || after_reset) begin
      assert (!axi_arvalid) else fail_value("axi_arvalid", axi_arvalid, 0);
      assert (!axi_awvalid) else fail_value("axi_awvalid", axi_awvalid, 0);
      assert (!axi_wvalid) else fail_value("axi_wvalid", axi_wvalid, 0);
      assert (!full) else fail_value("full", full, 0);
      assert (result_valid == '0) else fail_value("result_valid", result_valid, 0);
    end
    assert (axi_awvalid == axi_wvalid) else fail_value("axi_wvalid", axi_wvalid, axi_awvalid);
    if (axi_awvalid) begin
      assert (axi_aw.addr == cur_store.addr)
        else fail_value("axi_aw.addr", axi_aw.addr, cur_store.addr);
      assert (axi_aw.size == cur_store.size)
        else fail_value("axi_aw.size", axi_aw.size, cur_store.size);
      assert (axi_aw.wstrb == lane_mask(cur_store))
        else fail_value("axi_aw.wstrb", axi_aw.wstrb, lane_mask(cur_store));
      assert (axi_aw.wdata == lane_data(cur_store))
        else fail_value("axi_aw.wdata", axi_aw.wdata, lane_data(cur_store));
    end
    if (axi_arvalid) begin
      assert (ar_matches_load(axi_ar))
        else fail_text("read address and size match no pending load");
    end
    if (!reset) begin
      assert (axi_rready) else fail_value("axi_rready", axi_rready, 1);
      assert (axi_bready) else fail_value("axi_bready", axi_bready, 1);
      for (int i = 0; i < `LSU_UNITS; i++) begin
        if (result_valid[i]) begin
          check_result(result[i]);
        end
      end
      assert (full == (in_flight == `LSU_UNITS))
        else fail_value("full", full, in_flight == `LSU_UNITS);
      if (full) begin
        saw_full = 1'b1;
      end
      if (req_valid) begin
        in_flight++; // Taken from the next cycle on
      end
    end
    after_reset = reset;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus

  task automatic send(input logic write, input lsu_size_e size, input logic sext,
                      input lsu_addr_t addr, input lsu_data_t wsrc);
    lsu_req_t r;
    logic err;
    int waited;
    waited = 0;
    @(posedge clock);
    while (in_flight >= `LSU_UNITS || exp_pending[next_tag]) begin
      req_valid <= 1'b0;
      @(posedge clock);
      waited++;
      if (waited > TIMEOUT) begin
        fail_text("timed out waiting for an idle unit");
      end
    end
    r.write = write;
    r.size = size;
    r.sext = sext;
    r.addr = addr;
    r.wsrc = wsrc;
    r.tag = next_tag;
    err = (addr[31:12] == `LSU_ERR_BASE);
    sent_req[next_tag] = r;
    exp_pending[next_tag] = 1'b1;
    exp_write[next_tag] = write;
    exp_error[next_tag] = err;
    exp_check[next_tag] = !err;
    exp_data[next_tag] = write ? '0 : shadow_load(r);
    if (write) begin
      cur_store = r;
      if (!err) begin
        shadow_store(r);
      end
    end
    req_valid <= 1'b1;
    req <= r;
    next_tag = next_tag + 1'b1;
  endtask

  task automatic wait_all();
    int waited;
    waited = 0;
    @(posedge clock);
    req_valid <= 1'b0;
    while (in_flight != 0) begin
      @(posedge clock);
      waited++;
      if (waited > TIMEOUT) begin
        fail_text("timed out waiting for outstanding results");
      end
    end
  endtask

  task automatic wait_full();
    int waited;
    waited = 0;
    @(posedge clock);
    req_valid <= 1'b0;
    while (!saw_full) begin
      @(posedge clock);
      waited++;
      if (waited > TIMEOUT) begin
        fail_text("full never rose with every unit busy");
      end
    end
  endtask

  function automatic lsu_addr_t rand_addr(input lsu_size_e size);
    logic [1:0] off;
    off = $random(seed) & 3;
    if (size == SIZE_HALF) begin
      off = off & 2'b10;
    end
    if (size == SIZE_WORD) begin
      off = 2'b00;
    end
    return 32'h100 + 4 * ($random(seed) & 15) + off;
  endfunction

  initial begin
    lsu_size_e size;
    seed = 32'h216c_5548;
    reset = 1'b1;
    req_valid = 1'b0;
    req = '0;
    stall = 1'b0;
    in_flight = 0;
    after_reset = 1'b0;
    saw_full = 1'b0;
    cur_store = '0;
    next_tag = '0;
    for (int t = 0; t < TAGS; t++) begin
      exp_pending[t] = 1'b0;
      sent_req[t] = '0;
    end
    for (int a = 0; a < 4096; a++) begin
      shadow[a] = 8'h00;
    end
    repeat (3) @(posedge clock);
    reset <= 1'b0;

    for (int w = 0; w < 16; w++) begin // Word stores cover the test region
      send(1'b1, SIZE_WORD, 1'b0, 32'h100 + 4 * w, $random(seed));
      wait_all();
    end

    repeat (3) begin
      repeat (6) begin
        size = lsu_size_e'($unsigned($random(seed)) % 3);
        send(1'b1, size, 1'b0, rand_addr(size), $random(seed));
        wait_all();
      end
      for (int i = 0; i < 12; i++) begin
        size = lsu_size_e'(i % 3);
        send(1'b0, size, (i / 3) % 2, rand_addr(size), '0);
        wait_all();
      end
    end

    // Concurrency with the memory stalled until every unit is taken
    stall <= 1'b1;
    saw_full = 1'b0;
    for (int i = 0; i < 12; i++) begin
      if (i == `LSU_UNITS) begin
        wait_full();
        stall <= 1'b0;
      end
      size = lsu_size_e'(i % 3);
      send(1'b0, size, i[0], rand_addr(size), '0);
    end
    wait_all();

    send(1'b1, SIZE_WORD, 1'b0, {`LSU_ERR_BASE, 12'h010}, $random(seed));
    wait_all();
    send(1'b0, SIZE_WORD, 1'b0, {`LSU_ERR_BASE, 12'h010}, '0);
    wait_all();
    send(1'b0, SIZE_BYTE, 1'b1, {`LSU_ERR_BASE, 12'h013}, '0);
    wait_all();
    send(1'b1, SIZE_WORD, 1'b0, {`LSU_ERR_BASE - 20'd1, 12'hffc}, $random(seed)); // Page below
    wait_all();
    send(1'b0, SIZE_WORD, 1'b0, {`LSU_ERR_BASE - 20'd1, 12'hffc}, '0);
    wait_all();
    send(1'b1, SIZE_HALF, 1'b0, {`LSU_ERR_BASE + 20'd1, 12'h002}, $random(seed)); // Page above
    wait_all();
    send(1'b0, SIZE_HALF, 1'b1, {`LSU_ERR_BASE + 20'd1, 12'h002}, '0);
    wait_all();

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire
